//--- src/chip_io_pkg.sv
// Shared types for the chip I/O slice
// Pad variants, pad drive and attribute structs, default pad counts

package chip_io_pkg;

  //////////////////////////////
  // Pad counts and indexing
  //////////////////////////////

  localparam int PadIdxW     = 5;  // Up to 32 pads in joint index
  localparam int NMioPadsDef = 8;  // Muxed IOs, index 0 upward
  localparam int NDioPadsDef = 4;  // Dedicated IOs follow the MIOs

  //////////////////////////////
  // Pad types
  //////////////////////////////

  // Encoding follows the full padring, value 2 was the USB variant
  typedef enum logic [1:0] {
    PadBidir     = 2'd0,  // Plain bidirectional
    PadInOnly    = 2'd1,  // Receiver only
    PadOpenDrain = 2'd3   // Pull-down only
  } pad_variant_e;

  typedef struct packed {
    logic invert;  // Flip out and in
    logic od_en;   // Virtual open drain on bidir pads
  } pad_attr_t;

  typedef struct packed {
    logic out;  // Output level
    logic oe;   // Output enable
  } pad_sig_t;

  // One attribute write from the core
  typedef struct packed {
    logic               we;    // One-cycle strobe
    logic [PadIdxW-1:0] addr;  // Joint pad index
    pad_attr_t          attr;  // New attribute value
  } attr_wr_t;

endpackage : chip_io_pkg

//--- src/padring.sv
// Pad ring model with fixed variant per pad
// Applies invert and open-drain attributes on both directions

module padring #(
  parameter int NMioPads = chip_io_pkg::NMioPadsDef,
  parameter int NDioPads = chip_io_pkg::NDioPadsDef,
  parameter chip_io_pkg::pad_variant_e [NMioPads-1:0] MioVariant =
    '{default: chip_io_pkg::PadBidir},
  parameter chip_io_pkg::pad_variant_e [NDioPads-1:0] DioVariant =
    '{default: chip_io_pkg::PadBidir}
) (
  // Attributes from register bank
  input  chip_io_pkg::pad_attr_t [NMioPads+NDioPads-1:0] attr_i,
  // Mux side
  input  chip_io_pkg::pad_sig_t  [NMioPads+NDioPads-1:0] mux_o_i,
  output logic                   [NMioPads+NDioPads-1:0] mux_in_o,
  // Pad side
  input  logic                   [NMioPads+NDioPads-1:0] pad_in_i,
  output chip_io_pkg::pad_sig_t  [NMioPads+NDioPads-1:0] pad_o
);

  localparam int NumIOs = NMioPads + NDioPads;  // Joint MIO + DIO count

  //////////////////////////////
  // Output drive rules
  //////////////////////////////

  // Resolve one pad's drive from its variant and attributes
  function automatic chip_io_pkg::pad_sig_t drive_pad(
    input chip_io_pkg::pad_variant_e variant,
    input chip_io_pkg::pad_attr_t    attr,
    input chip_io_pkg::pad_sig_t     sig
  );
    chip_io_pkg::pad_sig_t drv;
    logic                  out_eff;
    out_eff = sig.out ^ attr.invert;  // Inversion applied first
    drv     = '0;                     // Default is released
    case (variant)
      chip_io_pkg::PadBidir: begin
        if (attr.od_en) begin
          drv.oe = sig.oe & ~out_eff;  // Only pull low
        end else begin
          drv.out = out_eff;
          drv.oe  = sig.oe;
        end
      end
      chip_io_pkg::PadOpenDrain: begin
        drv.oe = sig.oe & ~out_eff;  // Drive 0 when out is low
      end
      default: begin
        drv = '0;  // Input only never drives
      end
    endcase
    return drv;
  endfunction

  //////////////////////////////
  // Per-pad instances
  //////////////////////////////

  for (genvar i = 0; i < NumIOs; i++) begin : gen_pad
    chip_io_pkg::pad_variant_e variant;  // Fixed per pad

    if (i < NMioPads) begin : gen_mio
      assign variant = MioVariant[i];
    end else begin : gen_dio
      assign variant = DioVariant[i - NMioPads];
    end

    assign pad_o[i]    = drive_pad(variant, attr_i[i], mux_o_i[i]);
    assign mux_in_o[i] = pad_in_i[i] ^ attr_i[i].invert;  // Input side inversion
  end

endmodule : padring

//--- src/padctrl_regs.sv
// Pad attribute register bank
// One register per pad, written by a single-cycle strobe

module padctrl_regs #(
  parameter int NumPads = chip_io_pkg::NMioPadsDef + chip_io_pkg::NDioPadsDef
) (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  // Write port from the core
  input  chip_io_pkg::attr_wr_t                attr_wr_i,
  // Current attributes, one per pad
  output chip_io_pkg::pad_attr_t [NumPads-1:0] attr_o
);

  //////////////////////////////
  // Address decode
  //////////////////////////////

  logic [NumPads-1:0] wr_hit;  // One-hot write select

  // Out of range addresses match no pad and are dropped
  always_comb begin
    wr_hit = '0;
    for (int i = 0; i < NumPads; i++) begin
      if (attr_wr_i.we && (attr_wr_i.addr == chip_io_pkg::PadIdxW'(i))) begin
        wr_hit[i] = 1'b1;
      end
    end
  end

  //////////////////////////////
  // Attribute registers
  //////////////////////////////

  chip_io_pkg::pad_attr_t [NumPads-1:0] attr_q;  // Cleared to no invert, no OD

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      attr_q <= '0;
    end else begin
      for (int i = 0; i < NumPads; i++) begin
        if (wr_hit[i]) begin
          attr_q[i] <= attr_wr_i.attr;  // Visible right after the strobe edge
        end
      end
    end
  end

  assign attr_o = attr_q;  // Feeds padring combinationally

endmodule : padctrl_regs

//--- src/jtag_mux.sv
// JTAG overlay mux between core and padring
// Synchronizes the enable pad, then takes over the JTAG pads

module jtag_mux #(
  parameter int                NumIOs         = 12,
  parameter logic [NumIOs-1:0] TieOffValues   = '0,
  parameter int                JtagEnIdx      = 7,
  parameter logic              JtagEnPolarity = 1'b1,
  parameter int                TckIdx         = 11,
  parameter int                TmsIdx         = 10,
  parameter int                TdiIdx         = 9,
  parameter int                TdoIdx         = 8,
  parameter int                TrstIdx        = 6
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  // Core side
  input  chip_io_pkg::pad_sig_t [NumIOs-1:0] core_o_i,
  output logic                  [NumIOs-1:0] core_in_o,
  // Padring side
  output chip_io_pkg::pad_sig_t [NumIOs-1:0] mux_o,
  input  logic                  [NumIOs-1:0] mux_in_i,
  // JTAG TAP in the core
  input  logic                                jtag_tdo_i,
  output logic                                jtag_tck_o,
  output logic                                jtag_tms_o,
  output logic                                jtag_tdi_o,
  output logic                                jtag_trst_n_o,
  output logic                                jtag_active_o
);

  //////////////////////////////
  // Overlay masks
  //////////////////////////////

  // Pads whose core input is tied off while JTAG owns them
  localparam logic [NumIOs-1:0] InMask = (NumIOs'(1) << TckIdx)  |
                                         (NumIOs'(1) << TmsIdx)  |
                                         (NumIOs'(1) << TdiIdx)  |
                                         (NumIOs'(1) << TdoIdx)  |
                                         (NumIOs'(1) << TrstIdx);

  // JTAG input pads, released while active
  localparam logic [NumIOs-1:0] HizMask = (NumIOs'(1) << TckIdx)  |
                                          (NumIOs'(1) << TmsIdx)  |
                                          (NumIOs'(1) << TdiIdx)  |
                                          (NumIOs'(1) << TrstIdx);

  //////////////////////////////
  // Enable synchronizer
  //////////////////////////////

  logic       jtag_en_req;  // Enable pad at its active level
  logic [1:0] jtag_en_q;    // Two-flop sync chain

  assign jtag_en_req = (mux_in_i[JtagEnIdx] == JtagEnPolarity);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      jtag_en_q <= 2'b00;
    end else begin
      jtag_en_q <= {jtag_en_q[0], jtag_en_req};  // Shift toward bit 1
    end
  end

  assign jtag_active_o = jtag_en_q[1];  // Second edge after the pad level

  //////////////////////////////
  // Overlay
  //////////////////////////////

  always_comb begin
    mux_o     = core_o_i;  // Pass through by default
    core_in_o = mux_in_i;
    if (jtag_active_o) begin
      for (int i = 0; i < NumIOs; i++) begin
        if (InMask[i]) begin
          core_in_o[i] = TieOffValues[i];  // Hide JTAG pads from core
        end
        if (HizMask[i]) begin
          mux_o[i].oe = 1'b0;
        end
      end
      mux_o[TdoIdx].out = jtag_tdo_i;  // TAP drives TDO pad
      mux_o[TdoIdx].oe  = 1'b1;
    end
  end

  // TAP inputs held inactive unless overlay is on
  assign jtag_tck_o    = jtag_active_o & mux_in_i[TckIdx];
  assign jtag_tms_o    = jtag_active_o & mux_in_i[TmsIdx];
  assign jtag_tdi_o    = jtag_active_o & mux_in_i[TdiIdx];
  assign jtag_trst_n_o = jtag_active_o & mux_in_i[TrstIdx];  // TAP in reset when off

endmodule : jtag_mux

//--- src/chip_io_top.sv
// Chip I/O top level with pad map and JTAG overlay settings
// Connects attribute regs, JTAG mux and padring

module chip_io_top #(
  parameter int NMioPads = chip_io_pkg::NMioPadsDef,
  parameter int NDioPads = chip_io_pkg::NDioPadsDef,
  parameter chip_io_pkg::pad_variant_e [NMioPads-1:0] MioVariant = '{
    chip_io_pkg::PadOpenDrain,  // MIO 7, JTAG enable
    chip_io_pkg::PadOpenDrain,  // MIO 6, TRST
    chip_io_pkg::PadBidir, chip_io_pkg::PadBidir, chip_io_pkg::PadBidir,
    chip_io_pkg::PadBidir, chip_io_pkg::PadBidir, chip_io_pkg::PadBidir
  },
  parameter chip_io_pkg::pad_variant_e [NDioPads-1:0] DioVariant = '{
    chip_io_pkg::PadInOnly,  // DIO 3, TCK
    chip_io_pkg::PadInOnly,  // DIO 2, TMS
    chip_io_pkg::PadBidir,   // DIO 1, TDI
    chip_io_pkg::PadBidir    // DIO 0, TDO
  },
  parameter int   JtagEnIdx      = 7,  // MIO 7
  parameter logic JtagEnPolarity = 1'b1,
  parameter int   TckIdx         = NMioPads + 3,
  parameter int   TmsIdx         = NMioPads + 2,
  parameter int   TdiIdx         = NMioPads + 1,
  parameter int   TdoIdx         = NMioPads + 0,
  parameter int   TrstIdx        = 6   // MIO 6
) (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  // Pad side
  input  logic                  [NMioPads+NDioPads-1:0] pad_in_i,
  output chip_io_pkg::pad_sig_t [NMioPads+NDioPads-1:0] pad_o,
  // Core side
  input  chip_io_pkg::pad_sig_t [NMioPads+NDioPads-1:0] core_o_i,
  output logic                  [NMioPads+NDioPads-1:0] core_in_o,
  input  chip_io_pkg::attr_wr_t                         attr_wr_i,
  // JTAG
  input  logic                                          jtag_tdo_i,
  output logic                                          jtag_tck_o,
  output logic                                          jtag_tms_o,
  output logic                                          jtag_tdi_o,
  output logic                                          jtag_trst_n_o,
  output logic                                          jtag_active_o
);

  localparam int NumIOs = NMioPads + NDioPads;
  localparam logic [NumIOs-1:0] TieOffValues = NumIOs'(1) << TmsIdx;  // TMS idles high

  chip_io_pkg::pad_attr_t [NumIOs-1:0] attrs;   // Regs to padring
  chip_io_pkg::pad_sig_t  [NumIOs-1:0] mux_o;   // Mux to padring
  logic                   [NumIOs-1:0] mux_in;  // Padring to mux

  padctrl_regs #(
    .NumPads ( NumIOs )
  ) u_padctrl_regs (
    .clk_i     ( clk_i     ),
    .rst_n_i   ( rst_n_i   ),
    .attr_wr_i ( attr_wr_i ),
    .attr_o    ( attrs     )
  );

  jtag_mux #(
    .NumIOs         ( NumIOs         ),
    .TieOffValues   ( TieOffValues   ),
    .JtagEnIdx      ( JtagEnIdx      ),
    .JtagEnPolarity ( JtagEnPolarity ),
    .TckIdx         ( TckIdx         ),
    .TmsIdx         ( TmsIdx         ),
    .TdiIdx         ( TdiIdx         ),
    .TdoIdx         ( TdoIdx         ),
    .TrstIdx        ( TrstIdx        )
  ) u_jtag_mux (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .core_o_i      ( core_o_i      ),
    .core_in_o     ( core_in_o     ),
    .mux_o         ( mux_o         ),
    .mux_in_i      ( mux_in        ),
    .jtag_tdo_i    ( jtag_tdo_i    ),
    .jtag_tck_o    ( jtag_tck_o    ),
    .jtag_tms_o    ( jtag_tms_o    ),
    .jtag_tdi_o    ( jtag_tdi_o    ),
    .jtag_trst_n_o ( jtag_trst_n_o ),
    .jtag_active_o ( jtag_active_o )
  );

  padring #(
    .NMioPads   ( NMioPads   ),
    .NDioPads   ( NDioPads   ),
    .MioVariant ( MioVariant ),
    .DioVariant ( DioVariant )
  ) u_padring (
    .attr_i   ( attrs    ),
    .mux_o_i  ( mux_o    ),
    .mux_in_o ( mux_in   ),
    .pad_in_i ( pad_in_i ),
    .pad_o    ( pad_o    )
  );

endmodule : chip_io_top

//--- verification/chip_io_chk.sv
// Bound checker for the chip I/O top level
// Attribute shadow, enable sync model, pad and JTAG assertions

module chip_io_chk #(
  parameter int NMioPads = chip_io_pkg::NMioPadsDef,
  parameter int NDioPads = chip_io_pkg::NDioPadsDef,
  parameter chip_io_pkg::pad_variant_e [NMioPads-1:0] MioVariant =
    '{default: chip_io_pkg::PadBidir},
  parameter chip_io_pkg::pad_variant_e [NDioPads-1:0] DioVariant =
    '{default: chip_io_pkg::PadBidir},
  parameter int   JtagEnIdx      = 7,
  parameter logic JtagEnPolarity = 1'b1,
  parameter int   TckIdx         = 11,
  parameter int   TmsIdx         = 10,
  parameter int   TdiIdx         = 9,
  parameter int   TdoIdx         = 8,
  parameter int   TrstIdx        = 6
) (
  input logic                                          clk_i,
  input logic                                          rst_n_i,
  input logic                  [NMioPads+NDioPads-1:0] pad_in_i,
  input chip_io_pkg::pad_sig_t [NMioPads+NDioPads-1:0] pad_o,
  input chip_io_pkg::pad_sig_t [NMioPads+NDioPads-1:0] core_o_i,
  input logic                  [NMioPads+NDioPads-1:0] core_in_o,
  input chip_io_pkg::attr_wr_t                         attr_wr_i,
  input logic                                          jtag_tdo_i,
  input logic                                          jtag_tck_o,
  input logic                                          jtag_tms_o,
  input logic                                          jtag_tdi_o,
  input logic                                          jtag_trst_n_o,
  input logic                                          jtag_active_o
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NumIOs = NMioPads + NDioPads;
  localparam logic [2*NumIOs-1:0] VarBits = {DioVariant, MioVariant};  // Joint pad map

  chip_io_pkg::pad_attr_t [NumIOs-1:0] attr_sh;  // Attributes as the core wrote them
  chip_io_pkg::pad_sig_t  [NumIOs-1:0] exp_pad;
  chip_io_pkg::pad_sig_t               drv;
  logic                   [NumIOs-1:0] exp_in;
  logic                   [NumIOs-1:0] pad_lvl;  // Pad level after input inversion
  logic                   [3:0]        exp_tap;  // TCK, TMS, TDI, TRST_N
  logic                   [1:0]        en_sync;
  logic                   [1:0]        vt;
  logic                                ovl;
  logic                                err_seen = 1'b0;  // Read by the testbench

  //////////////////////////////
  // Reference state
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      attr_sh <= '0;
      en_sync <= 2'b00;
    end else begin
      for (int i = 0; i < NumIOs; i++) begin
        if (attr_wr_i.we && int'(attr_wr_i.addr) == i) begin
          attr_sh[i] <= attr_wr_i.attr;  // Out of range hits nothing
        end
      end
      en_sync <= {en_sync[0],
                  (pad_in_i[JtagEnIdx] ^ attr_sh[JtagEnIdx].invert) == JtagEnPolarity};
    end
  end

  //////////////////////////////
  // Expected outputs
  //////////////////////////////

  always_comb begin
    exp_pad = '0;
    exp_in  = '0;
    pad_lvl = '0;
    for (int i = 0; i < NumIOs; i++) begin
      drv        = core_o_i[i];
      pad_lvl[i] = pad_in_i[i] ^ attr_sh[i].invert;
      exp_in[i]  = pad_lvl[i];
      ovl = (i == TckIdx) || (i == TmsIdx) || (i == TdiIdx) || (i == TrstIdx);
      if (en_sync[1] && (ovl || i == TdoIdx)) begin
        exp_in[i] = (i == TmsIdx);  // Tie-off, only TMS high
      end
      if (en_sync[1] && i == TdoIdx) begin
        drv.out = jtag_tdo_i;
        drv.oe  = 1'b1;
      end
      if (en_sync[1] && ovl) begin
        drv.oe = 1'b0;  // JTAG input pads released
      end
      drv.out = drv.out ^ attr_sh[i].invert;
      vt      = VarBits[2*i +: 2];
      if (vt == chip_io_pkg::PadInOnly) begin
        drv = '0;
      end else if (vt == chip_io_pkg::PadOpenDrain || attr_sh[i].od_en) begin
        drv.oe  = drv.oe & ~drv.out;  // Pull low only
        drv.out = 1'b0;
      end
      exp_pad[i] = drv;
    end
    exp_tap = {4{en_sync[1]}} &
              {pad_lvl[TckIdx], pad_lvl[TmsIdx], pad_lvl[TdiIdx], pad_lvl[TrstIdx]};
  end

  //////////////////////////////
  // Assertions
  //////////////////////////////

  a_active: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    jtag_active_o == en_sync[1])
    else begin
      err_seen = 1'b1;
      $error("Mismatch at %0t: jtag_active_o expected %b, got %b",
             $time, $sampled(en_sync[1]), $sampled(jtag_active_o));
    end

  a_pad: assert property (@(posedge clk_i) disable iff (!rst_n_i) pad_o == exp_pad)
    else begin
      err_seen = 1'b1;
      $error("Mismatch at %0t: pad_o expected %h, got %h",
             $time, $sampled(exp_pad), $sampled(pad_o));
    end

  a_core_in: assert property (@(posedge clk_i) disable iff (!rst_n_i) core_in_o == exp_in)
    else begin
      err_seen = 1'b1;
      $error("Mismatch at %0t: core_in_o expected %h, got %h",
             $time, $sampled(exp_in), $sampled(core_in_o));
    end

  a_tap: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    {jtag_tck_o, jtag_tms_o, jtag_tdi_o, jtag_trst_n_o} == exp_tap)
    else begin
      err_seen = 1'b1;
      $error("Mismatch at %0t: jtag tck/tms/tdi/trst_n expected %b, got %b", $time,
             $sampled(exp_tap),
             $sampled({jtag_tck_o, jtag_tms_o, jtag_tdi_o, jtag_trst_n_o}));
    end

endmodule : chip_io_chk

bind chip_io_top chip_io_chk #(
  .NMioPads       ( NMioPads       ),
  .NDioPads       ( NDioPads       ),
  .MioVariant     ( MioVariant     ),
  .DioVariant     ( DioVariant     ),
  .JtagEnIdx      ( JtagEnIdx      ),
  .JtagEnPolarity ( JtagEnPolarity ),
  .TckIdx         ( TckIdx         ),
  .TmsIdx         ( TmsIdx         ),
  .TdiIdx         ( TdiIdx         ),
  .TdoIdx         ( TdoIdx         ),
  .TrstIdx        ( TrstIdx        )
) u_chip_io_chk (.*);

//--- verification/chip_io_tb.sv
// Testbench for the chip I/O top level
// Random pad and core stimulus, attribute writes, JTAG entry and exit, watchdog

module chip_io_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NumIOs     = chip_io_pkg::NMioPadsDef + chip_io_pkg::NDioPadsDef;
  localparam int EnIdx      = 7;   // MIO 7 enables JTAG
  localparam int Rounds     = 4;   // Write rounds per attribute test
  localparam int JtagCycles = 24;
  localparam int TestCycles = 3 + 20 + 3 * Rounds * 14 + 2 * JtagCycles;
  localparam int TimeoutNs  = 4 * (TestCycles + 100);  // 4 ns period plus margin

  localparam chip_io_pkg::pad_attr_t InvAttr = '{invert: 1'b1, od_en: 1'b0};
  localparam chip_io_pkg::pad_attr_t OdAttr  = '{invert: 1'b0, od_en: 1'b1};

  logic                               clk_i = 1'b0;
  logic                               rst_n_i;
  logic                  [NumIOs-1:0] pad_in;
  chip_io_pkg::pad_sig_t [NumIOs-1:0] pad_o;
  chip_io_pkg::pad_sig_t [NumIOs-1:0] core_o;
  logic                  [NumIOs-1:0] core_in;
  chip_io_pkg::attr_wr_t              attr_wr;
  logic                               jtag_tdo;
  logic                               jtag_tck;
  logic                               jtag_tms;
  logic                               jtag_tdi;
  logic                               jtag_trst_n;
  logic                               jtag_active;

  always #2 clk_i = ~clk_i;

  chip_io_top UUT (
    .clk_i         ( clk_i       ),
    .rst_n_i       ( rst_n_i     ),
    .pad_in_i      ( pad_in      ),
    .pad_o         ( pad_o       ),
    .core_o_i      ( core_o      ),
    .core_in_o     ( core_in     ),
    .attr_wr_i     ( attr_wr     ),
    .jtag_tdo_i    ( jtag_tdo    ),
    .jtag_tck_o    ( jtag_tck    ),
    .jtag_tms_o    ( jtag_tms    ),
    .jtag_tdi_o    ( jtag_tdi    ),
    .jtag_trst_n_o ( jtag_trst_n ),
    .jtag_active_o ( jtag_active )
  );

  // Random pads and core drive, enable pad forced to en
  task automatic run_cycles(input int n, input logic en);
    for (int c = 0; c < n; c++) begin
      @(posedge clk_i);
      pad_in        <= NumIOs'($urandom);
      pad_in[EnIdx] <= en;
      core_o        <= (2*NumIOs)'($urandom);
      jtag_tdo      <= 1'($urandom);
      attr_wr.we    <= 1'b0;  // Strobe lasts one cycle
    end
  endtask

  task automatic write_attr(input logic [4:0] addr, input chip_io_pkg::pad_attr_t attr);
    @(posedge clk_i);
    attr_wr <= '{we: 1'b1, addr: addr, attr: attr};
  endtask

  // Set, hold, then clear one attribute
  task automatic attr_round(input logic [4:0] addr, input chip_io_pkg::pad_attr_t attr);
    write_attr(addr, attr);
    run_cycles(8, 1'b0);
    write_attr(addr, '0);
    run_cycles(4, 1'b0);
  endtask

  // MIO 0-5 or DIO 0-1
  function automatic logic [4:0] pick_bidir();
    int r;
    r = int'($urandom_range(7, 0));
    return (r < 6) ? 5'(r) : 5'(r + 2);
  endfunction

  initial begin
    void'($urandom(32'hbfd));
    rst_n_i  = 1'b0;
    pad_in   = '0;
    core_o   = '0;
    attr_wr  = '0;
    jtag_tdo = 1'b0;
    repeat (3) @(posedge clk_i);
    rst_n_i <= 1'b1;
    run_cycles(20, 1'b0);                   // Idle pass-through
    for (int r = 0; r < Rounds; r++) begin
      attr_round(pick_bidir(), InvAttr);
    end
    for (int r = 0; r < Rounds; r++) begin
      attr_round(pick_bidir(), OdAttr);
    end
    for (int r = 0; r < Rounds; r++) begin
      // Invert always set so a stray hit would show on core_in
      attr_round(5'($urandom_range(31, 12)),
                 chip_io_pkg::pad_attr_t'{invert: 1'b1, od_en: 1'($urandom)});
    end
    run_cycles(JtagCycles, 1'b1);           // Overlay on
    run_cycles(JtagCycles, 1'b0);           // And off again
    @(negedge clk_i);
    if (UUT.u_chip_io_chk.err_seen) begin
      $display("Simulation FAILED");
      $fatal(1, "Checker reported an error");
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

  // Stop at the first assertion failure
  always @(negedge clk_i) begin
    if (UUT.u_chip_io_chk.err_seen) begin
      $display("Simulation FAILED");
      $fatal(1, "Stopped at first checker error");
    end
  end

  initial begin
    #(TimeoutNs);
    $display("Timeout: stimulus did not finish within %0d ns", TimeoutNs);
    $display("Simulation FAILED");
    $fatal(1, "Watchdog expired");
  end

endmodule : chip_io_tb

//--- chip_io.f
src/chip_io_pkg.sv
src/padring.sv
src/padctrl_regs.sv
src/jtag_mux.sv
src/chip_io_top.sv
verification/chip_io_chk.sv
verification/chip_io_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the chip_io testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f chip_io.f --top-module chip_io_tb -o chip_io_sim

# Let the first assertion error reach the testbench instead of stopping at once
status=0
./obj_dir/chip_io_sim +verilator+error+limit+10 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
  echo "chip_io: run failed"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "chip_io: simulator exited with status $status"
  exit 1
fi
echo "chip_io: run passed"
